/* design/oflow_calc_min.sv */
`timescale 1ns/1ps

module oflow_calc_min (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  start_score_calc, // new job, clear both
	input  logic                  start_calc_min,   // merge the current pair
	input  oflow_core_pkg::score_t score_0,
	input  oflow_core_pkg::score_t score_1,
	input  oflow_core_pkg::id_t    id_0,
	input  oflow_core_pkg::id_t    id_1,
	output oflow_core_pkg::score_t min_score_0, // best
	output oflow_core_pkg::id_t    min_id_0,
	output oflow_core_pkg::score_t min_score_1, // second best
	output oflow_core_pkg::id_t    min_id_1
);
	import oflow_core_pkg::*;

	score_t nx_score_0, nx_score_1;
	id_t    nx_id_0, nx_id_1;

	// ----------------------------------------
	// merge pair into best two
	// ----------------------------------------
	// strict less-than so older entries win ties
	always_comb begin
		nx_score_0 = min_score_0;
		nx_id_0    = min_id_0;
		nx_score_1 = min_score_1;
		nx_id_1    = min_id_1;

		// candidate 0 first
		if (score_0 < nx_score_0) begin
			nx_score_1 = nx_score_0; // old best drops to second
			nx_id_1    = nx_id_0;
			nx_score_0 = score_0;
			nx_id_0    = id_0;
		end else if (score_0 < nx_score_1) begin
			nx_score_1 = score_0;
			nx_id_1    = id_0;
		end

		// then candidate 1 against the updated pair
		if (score_1 < nx_score_0) begin
			nx_score_1 = nx_score_0;
			nx_id_1    = nx_id_0;
			nx_score_0 = score_1;
			nx_id_0    = id_1;
		end else if (score_1 < nx_score_1) begin
			nx_score_1 = score_1;
			nx_id_1    = id_1;
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			min_score_0 <= MAX_SCORE;
			min_id_0    <= '0;
			min_score_1 <= MAX_SCORE;
			min_id_1    <= '0;
		end else if (start_score_calc) begin
			min_score_0 <= MAX_SCORE;
			min_id_0    <= '0;
			min_score_1 <= MAX_SCORE;
			min_id_1    <= '0;
		end else if (start_calc_min) begin
			min_score_0 <= nx_score_0;
			min_id_0    <= nx_id_0;
			min_score_1 <= nx_score_1;
			min_id_1    <= nx_id_1;
		end
	end

	// best never ranks behind second, across every job
	min_ordered: assert property (@(posedge clk) disable iff (!reset_N)
		min_score_0 <= min_score_1)
		else $error("min order broken %h > %h", min_score_0, min_score_1);

endmodule

/* design/oflow_core_pkg.sv */
package oflow_core_pkg;

	// ----------------------------------------
	// feature geometry
	// ----------------------------------------
	localparam int ELEM_W     = 8;  // one feature element
	localparam int FEAT_ELEMS = 4;  // elements per feature word

	// ----------------------------------------
	// data types
	// ----------------------------------------
	typedef logic [FEAT_ELEMS*ELEM_W-1:0] feat_t;  // packed feature, element 0 in low byte
	typedef logic [9:0]                   score_t; // sad, real max 4*255 = 1020
	typedef logic [7:0]                   id_t;    // candidate id
	typedef logic [7:0]                   pair_cnt_t; // pairs per job

	// cleared value of the min registers, above any real score
	localparam score_t MAX_SCORE = '1;

	// pair buffer depth, also the credit the sender starts with
	localparam int IN_CREDITS = 2;

endpackage

/* design/oflow_ctrl_pkg.sv */
package oflow_ctrl_pkg;

	// ----------------------------------------
	// job controller
	// ----------------------------------------
	typedef enum logic [2:0] {
		idle_st,      // waiting for start
		wait_pair_st, // waiting for a pair in the buffer
		score_st,     // metrics hold the pair scores
		calc_min_st,  // min tracker merges the pair
		result_st     // waiting for a result credit
	} match_state_t;

	// result credits held, score board grants a few at most
	localparam int RES_CREDIT_W = 3;

endpackage

/* design/oflow_match_ctrl.sv */
`timescale 1ns/1ps

module oflow_match_ctrl (
	input  logic clk,
	input  logic reset_N,
	input  logic start,
	input  logic not_empty,
	input  logic last_pair,
	input  logic has_res_credit,
	output logic clear_job,    // latch job, clear min regs
	output logic pop,
	output logic load,         // metrics capture head pair
	output logic update,       // min tracker merge
	output logic result_valid, // also spends the credit
	output logic busy
);
	import oflow_ctrl_pkg::*;

	match_state_t state, next_state;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			state <= idle_st;
		else
			state <= next_state;
	end

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			idle_st:
				if (start)
					next_state = wait_pair_st;
			wait_pair_st:
				if (not_empty)
					next_state = score_st; // pair popped this cycle
			score_st:
				next_state = calc_min_st;
			calc_min_st:
				next_state = last_pair ? result_st : wait_pair_st;
			result_st:
				if (has_res_credit)
					next_state = idle_st;
			default:
				next_state = idle_st;
		endcase
	end

	// outputs straight from state
	assign clear_job    = (state == idle_st) && start;
	assign pop          = (state == wait_pair_st) && not_empty;
	assign load         = pop;  // head pair is valid in the pop cycle
	assign update       = (state == calc_min_st);
	assign result_valid = (state == result_st) && has_res_credit;
	assign busy         = (state != idle_st);

endmodule

/* design/oflow_match_top.sv */
`timescale 1ns/1ps

module oflow_match_top (
	input  logic                     clk,
	input  logic                     reset_N,
	// job start
	input  logic                     start,
	input  oflow_core_pkg::feat_t     ref_feat,
	input  oflow_core_pkg::pair_cnt_t num_pairs,
	// candidate pairs
	input  logic                     cand_valid,
	input  oflow_core_pkg::feat_t     cand_feat_0,
	input  oflow_core_pkg::id_t       cand_id_0,
	input  oflow_core_pkg::feat_t     cand_feat_1,
	input  oflow_core_pkg::id_t       cand_id_1,
	output logic                     cand_credit,
	// score board side
	input  logic                     res_credit,
	output logic                     result_valid,
	output oflow_core_pkg::score_t    min_score_0,
	output oflow_core_pkg::id_t       min_id_0,
	output oflow_core_pkg::score_t    min_score_1,
	output oflow_core_pkg::id_t       min_id_1,
	output logic                     busy
);
	import oflow_core_pkg::*;

	feat_t  head_feat_0, head_feat_1;
	id_t    head_id_0, head_id_1;
	score_t score_0, score_1;
	id_t    score_id_0, score_id_1;
	logic   not_empty, last_pair, has_res_credit;
	logic   clear_job, pop, load, update;

	oflow_pair_buffer u_buf (
		.clk, .reset_N, .push(cand_valid), .pop,
		.feat_0(cand_feat_0), .feat_1(cand_feat_1), .id_0(cand_id_0), .id_1(cand_id_1),
		.head_feat_0, .head_feat_1, .head_id_0, .head_id_1,
		.not_empty, .credit_return(cand_credit)
	);

	// one metric per candidate of the pair
	oflow_similarity_metric u_metric_0 (
		.clk, .reset_N, .latch_ref(clear_job), .load, .ref_feat,
		.cand_feat(head_feat_0), .cand_id(head_id_0), .score(score_0), .score_id(score_id_0)
	);
	oflow_similarity_metric u_metric_1 (
		.clk, .reset_N, .latch_ref(clear_job), .load, .ref_feat,
		.cand_feat(head_feat_1), .cand_id(head_id_1), .score(score_1), .score_id(score_id_1)
	);

	oflow_calc_min u_calc_min (
		.clk, .reset_N, .start_score_calc(clear_job), .start_calc_min(update),
		.score_0, .score_1, .id_0(score_id_0), .id_1(score_id_1),
		.min_score_0, .min_id_0, .min_score_1, .min_id_1
	);

	oflow_pair_counter u_cnt (
		.clk, .reset_N, .clear(clear_job), .num_pairs, .pair_done(update),
		.res_credit, .res_spend(result_valid), .last_pair, .has_res_credit
	);

	oflow_match_ctrl u_ctrl (
		.clk, .reset_N, .start, .not_empty, .last_pair, .has_res_credit,
		.clear_job, .pop, .load, .update, .result_valid, .busy
	);

endmodule

/* design/oflow_pair_buffer.sv */
`timescale 1ns/1ps

module oflow_pair_buffer (
	input  logic                 clk,
	input  logic                 reset_N,
	input  logic                 push,
	input  logic                 pop,
	input  oflow_core_pkg::feat_t feat_0,
	input  oflow_core_pkg::feat_t feat_1,
	input  oflow_core_pkg::id_t   id_0,
	input  oflow_core_pkg::id_t   id_1,
	output oflow_core_pkg::feat_t head_feat_0,
	output oflow_core_pkg::feat_t head_feat_1,
	output oflow_core_pkg::id_t   head_id_0,
	output oflow_core_pkg::id_t   head_id_1,
	output logic                 not_empty,
	output logic                 credit_return
);
	import oflow_core_pkg::*;

	localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
	localparam int CNT_W = $clog2(IN_CREDITS + 1);

	feat_t mem_feat_0 [IN_CREDITS]; // pair storage
	feat_t mem_feat_1 [IN_CREDITS];
	id_t   mem_id_0   [IN_CREDITS];
	id_t   mem_id_1   [IN_CREDITS];

	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] fill;  // entries held
	logic             full;
	logic             pop_ok;

	assign full      = (fill == CNT_W'(IN_CREDITS));
	assign not_empty = (fill != '0);
	assign pop_ok    = pop && not_empty;

	// write side, no reset on storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem_feat_0[wr_ptr] <= feat_0;
			mem_feat_1[wr_ptr] <= feat_1;
			mem_id_0[wr_ptr]   <= id_0;
			mem_id_1[wr_ptr]   <= id_1;
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop_ok})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill; // idle or push+pop
			endcase
		end
	end

	assign head_feat_0   = mem_feat_0[rd_ptr];
	assign head_feat_1   = mem_feat_1[rd_ptr];
	assign head_id_0     = mem_id_0[rd_ptr];
	assign head_id_1     = mem_id_1[rd_ptr];
	assign credit_return = pop_ok; // one credit back per pair removed

	// sender must hold a credit for every push
	push_not_full: assert property (@(posedge clk) disable iff (!reset_N) push |-> !full)
		else $error("pair buffer push while full");

endmodule

/* design/oflow_pair_counter.sv */
`timescale 1ns/1ps

module oflow_pair_counter (
	input  logic                     clk,
	input  logic                     reset_N,
	input  logic                     clear,     // job start
	input  oflow_core_pkg::pair_cnt_t num_pairs,
	input  logic                     pair_done, // min tracker update
	input  logic                     res_credit,
	input  logic                     res_spend,
	output logic                     last_pair,
	output logic                     has_res_credit
);
	import oflow_core_pkg::*;
	import oflow_ctrl_pkg::*;

	pair_cnt_t               num_q;    // job length
	pair_cnt_t               done_cnt; // pairs merged so far
	logic [RES_CREDIT_W-1:0] res_cnt;  // result credits held

	always_ff @(posedge clk) begin
		if (clear)
			num_q <= num_pairs;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			done_cnt <= '0;
		else if (clear)
			done_cnt <= '0;
		else if (pair_done)
			done_cnt <= done_cnt + 1'b1;
	end

	assign last_pair = (done_cnt == num_q - 1'b1); // pair under update is final

	// ----------------------------------------
	// result credits
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			res_cnt <= '0;
		else
			res_cnt <= res_cnt + RES_CREDIT_W'(res_credit) - RES_CREDIT_W'(res_spend);
	end

	assign has_res_credit = (res_cnt != '0);

	// a result is only emitted against a held credit
	res_no_underflow: assert property (@(posedge clk) disable iff (!reset_N)
		res_spend |-> (res_cnt != '0))
		else $error("result credit underflow");

endmodule

/* design/oflow_similarity_metric.sv */
`timescale 1ns/1ps

module oflow_similarity_metric (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  latch_ref, // job start, capture reference
	input  logic                  load,
	input  oflow_core_pkg::feat_t  ref_feat,
	input  oflow_core_pkg::feat_t  cand_feat,
	input  oflow_core_pkg::id_t    cand_id,
	output oflow_core_pkg::score_t score,
	output oflow_core_pkg::id_t    score_id
);
	import oflow_core_pkg::*;

	feat_t             ref_q;  // reference for the whole job
	score_t            sad;
	logic [ELEM_W-1:0] elem_r, elem_c, elem_d;

	always_ff @(posedge clk) begin
		if (latch_ref)
			ref_q <= ref_feat;
	end

	// ----------------------------------------
	// sum of absolute differences
	// ----------------------------------------
	always_comb begin
		sad    = '0;
		elem_r = '0;
		elem_c = '0;
		elem_d = '0;
		for (int i = 0; i < FEAT_ELEMS; i++) begin
			elem_r = ref_q[i*ELEM_W +: ELEM_W];
			elem_c = cand_feat[i*ELEM_W +: ELEM_W];
			elem_d = (elem_r > elem_c) ? elem_r - elem_c : elem_c - elem_r; // |r - c|
			sad    = sad + score_t'(elem_d);
		end
	end

	// score and id travel together into the min tracker
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			score    <= '0;
			score_id <= '0;
		end else if (load) begin
			score    <= sad;
			score_id <= cand_id;
		end
	end

endmodule

/* src.f */
design/oflow_core_pkg.sv
design/oflow_ctrl_pkg.sv
design/oflow_pair_buffer.sv
design/oflow_similarity_metric.sv
design/oflow_calc_min.sv
design/oflow_pair_counter.sv
design/oflow_match_ctrl.sv
design/oflow_match_top.sv
test/oflow_match_tb.sv

/* test/oflow_match_tb.sv */
`timescale 1ns/1ps

module oflow_match_tb;
	import oflow_core_pkg::*;

	localparam int TOTAL_PAIRS = 12 + 4 + 5 + 1; // pairs over all jobs
	localparam int TIMEOUT     = 60 * TOTAL_PAIRS + 200;
	localparam int HOLD_CYCLES = 20;             // back-pressure window

	logic      clk = 1'b0;
	logic      reset_N, start, cand_valid, res_credit;
	feat_t     ref_feat, cand_feat_0, cand_feat_1;
	pair_cnt_t num_pairs;
	id_t       cand_id_0, cand_id_1, min_id_0, min_id_1;
	logic      cand_credit, result_valid, busy;
	score_t    min_score_0, min_score_1;

	int     seed = 9;
	int     credits = IN_CREDITS; // sender side mirror of the buffer depth
	int     credit_pulses, res_pulses, cycles, errors, tests_run, tests_failed;
	logic   hold;                 // no result credit given yet
	score_t exp_score_0, exp_score_1;
	id_t    exp_id_0, exp_id_1;

	oflow_match_top dut (.*);

	always #20 clk = ~clk;

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (cand_credit) begin
			credits++;
			credit_pulses++;
		end
		if (result_valid)
			res_pulses++;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	res_s0: assert property (@(posedge clk) disable iff (!reset_N)
		result_valid |-> min_score_0 == exp_score_0)
		else begin
			errors++;
			$display("ERROR min_score_0 got %h expected %h", min_score_0, exp_score_0);
		end
	res_i0: assert property (@(posedge clk) disable iff (!reset_N)
		result_valid |-> min_id_0 == exp_id_0)
		else begin
			errors++;
			$display("ERROR min_id_0 got %h expected %h", min_id_0, exp_id_0);
		end
	res_s1: assert property (@(posedge clk) disable iff (!reset_N)
		result_valid |-> min_score_1 == exp_score_1)
		else begin
			errors++;
			$display("ERROR min_score_1 got %h expected %h", min_score_1, exp_score_1);
		end
	res_i1: assert property (@(posedge clk) disable iff (!reset_N)
		result_valid |-> min_id_1 == exp_id_1)
		else begin
			errors++;
			$display("ERROR min_id_1 got %h expected %h", min_id_1, exp_id_1);
		end
	credit_range: assert property (@(posedge clk) disable iff (!reset_N)
		credits >= 0 && credits <= IN_CREDITS)
		else begin
			errors++;
			$display("sender credit count left its range, now %0d", credits);
		end
	held_result: assert property (@(posedge clk) disable iff (!reset_N)
		hold |-> busy && !result_valid && $stable(min_score_0) && $stable(min_id_0)
			&& $stable(min_score_1) && $stable(min_id_1))
		else begin
			errors++;
			$display("result moved or was emitted without a result credit");
		end

	task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
		assert (got == exp)
			else begin
				errors++;
				$display("ERROR %s got %h expected %h", name, got, exp);
			end
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic score_t ref_sad(feat_t r, feat_t c);
		int acc;
		int d;
		acc = 0;
		for (int k = 0; k < FEAT_ELEMS; k++) begin
			d   = int'(r[k*8 +: 8]) - int'(c[k*8 +: 8]);
			acc = acc + ((d < 0) ? -d : d); // |r - c| per byte
		end
		return score_t'(acc);
	endfunction

	task automatic model_take(score_t s, id_t id);
		if (s < exp_score_0) begin
			exp_score_1 = exp_score_0; // old best becomes second
			exp_id_1    = exp_id_0;
			exp_score_0 = s;
			exp_id_0    = id;
		end else if (s < exp_score_1) begin
			exp_score_1 = s;
			exp_id_1    = id;
		end
	endtask

	task automatic finish_test(string name, int err_at_start);
		tests_run++;
		if (errors != err_at_start) begin
			tests_failed++;
			$display("test %s: FAIL", name);
		end else
			$display("test %s: ok", name);
	endtask

	// one job of n pairs
	// tie sends equal candidates with rising ids
	// credit_first grants the result credit along with start
	task automatic run_job(string name, int n, bit tie, bit credit_first);
		int    err0;
		int    sent;
		int    res0;
		feat_t tie_feat;
		err0 = errors;
		sent = 0;
		tie_feat = $random(seed);
		@(posedge clk);
		#2;
		start       = 1'b1;
		ref_feat    = $random(seed);
		num_pairs   = pair_cnt_t'(n);
		res_credit  = credit_first;
		exp_score_0 = MAX_SCORE;
		exp_score_1 = MAX_SCORE;
		exp_id_0    = '0;
		exp_id_1    = '0;
		credit_pulses = 0;
		res0          = res_pulses;
		while (sent < n) begin
			@(posedge clk);
			#2;
			start      = 1'b0;
			res_credit = 1'b0;
			if (credits > 0) begin
				cand_feat_0 = tie ? tie_feat : feat_t'($random(seed));
				cand_feat_1 = tie ? tie_feat : feat_t'($random(seed));
				cand_id_0   = tie ? id_t'(2 * sent) : id_t'($random(seed));
				cand_id_1   = tie ? id_t'(2 * sent + 1) : id_t'($random(seed));
				cand_valid  = 1'b1;
				credits--;
				model_take(ref_sad(ref_feat, cand_feat_0), cand_id_0);
				model_take(ref_sad(ref_feat, cand_feat_1), cand_id_1);
				sent++;
			end else
				cand_valid = 1'b0;
		end
		@(posedge clk);
		#2;
		cand_valid = 1'b0;
		if (!credit_first) begin
			while (credit_pulses < n)
				@(posedge clk);
			repeat (4) @(negedge clk); // last pop, score, update, then result held
			hold = 1'b1;
			repeat (HOLD_CYCLES) @(negedge clk);
			hold = 1'b0;
			@(posedge clk);
			#2;
			res_credit = 1'b1;
			@(posedge clk);
			#2;
			res_credit = 1'b0;
		end
		while (res_pulses == res0)
			@(posedge clk);
		repeat (5) @(negedge clk);
		check_val("result_valid pulses", res_pulses - res0, 1);
		check_val("cand_credit pulses", credit_pulses, n);
		finish_test(name, err0);
	endtask

	initial begin
		int err0;
		reset_N     = 1'b0;
		start       = 1'b0;
		ref_feat    = '0;
		num_pairs   = '0;
		cand_valid  = 1'b0;
		cand_feat_0 = '0;
		cand_feat_1 = '0;
		cand_id_0   = '0;
		cand_id_1   = '0;
		res_credit  = 1'b0;
		hold        = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		reset_N = 1'b1;

		// ---- quiet outputs after reset ----
		err0 = errors;
		@(negedge clk);
		check_val("result_valid", result_valid, 0);
		check_val("cand_credit", cand_credit, 0);
		check_val("busy", busy, 0);
		check_val("min_score_0", min_score_0, MAX_SCORE);
		check_val("min_score_1", min_score_1, MAX_SCORE);
		check_val("min_id_0", min_id_0, 0);
		check_val("min_id_1", min_id_1, 0);
		finish_test("reset", err0);

		run_job("random job of 12 pairs", 12, 1'b0, 1'b1);
		run_job("back-pressure", 4, 1'b0, 1'b0);
		run_job("equal scores", 5, 1'b1, 1'b1);
		run_job("single pair", 1, 1'b0, 1'b1);

		$display("tests run %0d, tests with errors %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
